// File: src.f
common/tdc_pkg.sv
capture/tdc_hit_capture.sv
capture/tdc_hit_store.sv
readout/tdc_result_conv.sv
readout/tdc_frame_out.sv
verilog/tdc_top.sv
sim/tdc_checker.sv
sim/tb_tdc.sv

// File: run_sim.sh
#!/bin/bash
# build and run the TDC readout testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_tdc -f src.f -o tb_tdc

out=$(./obj_dir/tb_tdc)
echo "$out"

if grep -q 'All tests passed!' <<< "$out"; then
    exit 0
else
    exit 1
fi

// File: sim/tb_tdc.sv
`timescale 1ns/10ps

module tb_tdc;
    import tdc_pkg::*;

    localparam int NROWS = 6;

    // ------------------------------
    // window table
    // ------------------------------
    // range, start phase ones, ready delay after close, restart offset, hit count
    int range_tab   [NROWS] = '{32'h0140, 32'h0200, 32'h00C0, 32'h0068, 32'h0100, 32'h0180};
    int sones_tab   [NROWS] = '{4, 10, 7, 20, 0, 32};
    int dly_tab     [NROWS] = '{0, 0, 0, 0, 8, 5};
    int restart_tab [NROWS] = '{0, 0, 0, 3, 0, 0};
    int nhit_tab    [NROWS] = '{1, 4, 0, 4, 2, 3};
    // per hit: edge offset after the start edge, stop phase ones
    int off_tab [NROWS][4] = '{'{5, 0, 0, 0}, '{3, 6, 9, 12}, '{0, 0, 0, 0},
                               '{1, 2, 4, 5}, '{2, 7, 0, 0}, '{10, 11, 12, 0}};
    int ph_tab  [NROWS][4] = '{'{20, 0, 0, 0}, '{12, 31, 32, 0}, '{0, 0, 0, 0},
                               '{5, 2, 9, 9}, '{16, 8, 0, 0}, '{32, 0, 31, 0}};

    logic               clk;
    logic               rst_n;
    logic               start_i;
    logic               stop_i;
    logic [PHASE_W-1:0] phase_i;
    logic [SPAD_W-1:0]  spad_i;
    logic [TOF_W-1:0]   range_i;
    logic               ready_i;
    logic [TOF_W-1:0]   data_o;
    logic [INT_W-1:0]   int_o;
    logic [NUM_W-1:0]   num_o;
    logic               last_o;
    logic               valid_o;
    logic               irq_o;

    logic [SPAD_W-1:0]  mask_row [4];
    int                 seed = 3;
    int                 cycle_cnt = 0;
    int                 limit = 0;
    int                 err_cnt;
    int                 chk_cnt;
    int                 pend_cnt;

    tdc_top i_dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .start_i (start_i),
        .stop_i  (stop_i),
        .phase_i (phase_i),
        .spad_i  (spad_i),
        .range_i (range_i),
        .ready_i (ready_i),
        .data_o  (data_o),
        .int_o   (int_o),
        .num_o   (num_o),
        .last_o  (last_o),
        .valid_o (valid_o),
        .irq_o   (irq_o)
    );

    tdc_checker i_chk (
        .clk       (clk),
        .rst_n     (rst_n),
        .ready_i   (ready_i),
        .data_i    (data_o),
        .int_i     (int_o),
        .num_i     (num_o),
        .last_i    (last_o),
        .valid_i   (valid_o),
        .irq_i     (irq_o),
        .err_cnt_o (err_cnt),
        .chk_cnt_o (chk_cnt),
        .pend_o    (pend_cnt)
    );

    always #50 clk = ~clk;

    function automatic logic [PHASE_W-1:0] therm_word(input int n);
        if (n >= PHASE_W) begin
            return '1;
        end
        return PHASE_W'((64'd1 << n) - 64'd1);
    endfunction

    function automatic int fine_of(input int n);
        return (n > 31) ? 31 : n;    // saturating thermometer decode
    endfunction

    // expected beats of one window, pushed before the window starts
    task automatic expect_row(input int r);
        int               coarse_max;
        int               stf;
        int               diff;
        int               nval;
        int               h;
        int               ones;
        logic [TOF_W-1:0] tof_exp [MAX_HITS];
        logic [INT_W-1:0] int_exp [MAX_HITS];
        coarse_max = range_tab[r] >> FINE_W;
        stf        = fine_of(sones_tab[r]);
        nval       = 0;
        for (h = 0; h < nhit_tab[r]; h++) begin
            if (off_tab[r][h] >= 1 && off_tab[r][h] <= coarse_max && nval < MAX_HITS) begin
                diff = (off_tab[r][h] - 1) * 32 + fine_of(ph_tab[r][h]) - (32 + stf);
                tof_exp[nval] = (diff < 0 || diff > range_tab[r]) ? TOF_OVER : TOF_W'(diff);
                ones = $countones(mask_row[h]);
                int_exp[nval] = (ones > 15) ? 4'hF : INT_W'(ones);
                nval++;
            end
        end
        if (nval == 0) begin
            i_chk.push_beat('0, '0, '0, 1'b0, 1'b1);    // empty frame marker beat
        end else begin
            for (h = 0; h < nval; h++) begin
                i_chk.push_beat(tof_exp[h], int_exp[h], NUM_W'(nval), h == nval - 1,
                                h == nval - 1);
            end
        end
    endtask

    // ------------------------------
    // one window: start, stops, close, readout
    // ------------------------------
    task automatic run_window(input int r);
        int last_k;
        int k;
        int h;
        last_k = (range_tab[r] >> FINE_W) + 1;    // closing edge
        for (h = 0; h < 4; h++) begin
            mask_row[h] = SPAD_W'($random(seed));
            if (h < nhit_tab[r] && off_tab[r][h] > last_k) begin
                last_k = off_tab[r][h];
            end
        end
        expect_row(r);
        ready_i = (dly_tab[r] == 0);
        start_i = 1'b1;
        range_i = TOF_W'(range_tab[r]);
        phase_i = therm_word(sones_tab[r]);
        for (k = 1; k <= last_k; k++) begin
            @(negedge clk);
            start_i = (restart_tab[r] == k);    // must be ignored inside the window
            stop_i  = 1'b0;
            phase_i = '0;
            spad_i  = '0;
            for (h = 0; h < nhit_tab[r]; h++) begin
                if (off_tab[r][h] == k) begin
                    stop_i  = 1'b1;
                    phase_i = therm_word(ph_tab[r][h]);
                    spad_i  = mask_row[h];
                end
            end
        end
        @(negedge clk);
        start_i = 1'b0;
        stop_i  = 1'b0;
        phase_i = '0;
        spad_i  = '0;
        repeat (dly_tab[r]) @(negedge clk);    // back-pressure
        ready_i = 1'b1;
        while (pend_cnt != 0 || irq_o) begin
            @(negedge clk);
        end
        repeat (2) @(negedge clk);
    endtask

    // cycle limit from the table
    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (limit > 0 && cycle_cnt > limit) begin
            $display("timeout after %0d cycles, frame never completed", cycle_cnt);
            $display("checks: %0d, errors: %0d", chk_cnt, err_cnt + 1);
            $display("Test failures found");
            $finish;
        end
    end

    initial begin
        clk     = 1'b0;
        rst_n   = 1'b0;
        start_i = 1'b0;
        stop_i  = 1'b0;
        phase_i = '0;
        spad_i  = '0;
        range_i = '0;
        ready_i = 1'b1;
        limit   = 10;
        for (int r = 0; r < NROWS; r++) begin
            limit += (range_tab[r] >> FINE_W) + 20 + dly_tab[r];
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        for (int r = 0; r < NROWS; r++) begin
            run_window(r);
        end
        $display("checks: %0d, errors: %0d", chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: sim/tdc_checker.sv
`timescale 1ns/10ps

module tdc_checker (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      ready_i,
    input  logic [tdc_pkg::TOF_W-1:0] data_i,
    input  logic [tdc_pkg::INT_W-1:0] int_i,
    input  logic [tdc_pkg::NUM_W-1:0] num_i,
    input  logic                      last_i,
    input  logic                      valid_i,
    input  logic                      irq_i,
    output int                        err_cnt_o,
    output int                        chk_cnt_o,
    output int                        pend_o
);
    import tdc_pkg::*;

    localparam int EXP_W = 2 + NUM_W + INT_W + TOF_W;

    logic [EXP_W-1:0] exp_q [$];    // {frame end, last, num, int, data}
    logic [EXP_W-1:0] exp_beat;
    logic             ready_q;
    logic             irq_q;
    logic             in_frame;
    logic             end_q;        // previous cycle carried the final beat

    initial begin
        err_cnt_o = 0;
        chk_cnt_o = 0;
        pend_o    = 0;
    end

    task automatic push_beat(input logic [TOF_W-1:0] data, input logic [INT_W-1:0] inten,
                             input logic [NUM_W-1:0] num, input logic last, input logic fin);
        exp_q.push_back({fin, last, num, inten, data});
        pend_o = exp_q.size();
    endtask

    task automatic check_field(input string name, input logic [31:0] exp_val,
                               input logic [31:0] got_val);
        chk_cnt_o++;
        if (exp_val !== got_val) begin
            err_cnt_o++;
            $display("ERROR %s: expected 0x%0h, got 0x%0h at %0t", name, exp_val, got_val, $time);
        end
    endtask

    task automatic report(input string what);
        err_cnt_o++;
        $display("%s at %0t", what, $time);
    endtask

    // ------------------------------
    // sampled on the rising edge, values of the cycle before
    // ------------------------------
    always @(posedge clk) begin
        if (!rst_n) begin
            ready_q  = 1'b0;
            irq_q    = 1'b0;
            in_frame = 1'b0;
            end_q    = 1'b0;
        end else begin
            if (end_q) begin
                check_field("irq_o", 32'd0, 32'(irq_i));    // irq gone after the frame
            end else if (irq_q && !irq_i) begin
                report("irq_o fell before the frame ended");
            end
            if (!irq_q && irq_i && exp_q.size() == 0) begin
                report("irq_o rose with no frame expected");
            end
            end_q = 1'b0;
            if (valid_i) begin
                if (exp_q.size() == 0) begin
                    report("valid_o high with no beat expected");
                end else begin
                    exp_beat = exp_q.pop_front();
                    if (!in_frame && !ready_q) begin
                        report("frame started while ready_i was low");
                    end
                    check_field("data_o", 32'(exp_beat[TOF_W-1:0]), 32'(data_i));
                    check_field("int_o", 32'(exp_beat[TOF_W +: INT_W]), 32'(int_i));
                    check_field("num_o", 32'(exp_beat[TOF_W+INT_W +: NUM_W]), 32'(num_i));
                    check_field("last_o", 32'(exp_beat[EXP_W-2]), 32'(last_i));
                    check_field("irq_o", 32'd1, 32'(irq_i));
                    in_frame = !exp_beat[EXP_W-1];
                    end_q    = exp_beat[EXP_W-1];
                end
            end else if (in_frame) begin
                report("valid_o dropped inside a frame");
                in_frame = 1'b0;
            end
            ready_q = ready_i;
            irq_q   = irq_i;
            pend_o  = exp_q.size();
        end
    end

endmodule

// File: verilog/tdc_top.sv
`timescale 1ns/10ps

module tdc_top (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        start_i,
    input  logic                        stop_i,
    input  logic [tdc_pkg::PHASE_W-1:0] phase_i,
    input  logic [tdc_pkg::SPAD_W-1:0]  spad_i,
    input  logic [tdc_pkg::TOF_W-1:0]   range_i,
    input  logic                        ready_i,
    output logic [tdc_pkg::TOF_W-1:0]   data_o,
    output logic [tdc_pkg::INT_W-1:0]   int_o,
    output logic [tdc_pkg::NUM_W-1:0]   num_o,
    output logic                        last_o,
    output logic                        valid_o,
    output logic                        irq_o
);
    import tdc_pkg::*;

    // ------------------------------
    // capture side
    // ------------------------------
    logic                win_start;
    logic                win_done;
    logic                hit_we;
    logic [COARSE_W-1:0] hit_coarse;
    logic [PHASE_W-1:0]  hit_phase;
    logic [SPAD_W-1:0]   hit_spad;
    logic [PHASE_W-1:0]  start_phase;
    logic [TOF_W-1:0]    win_range;
    logic [NUM_W-1:0]    hit_num;

    // readout side
    logic [NUM_W-1:0]    rd_idx;
    logic [COARSE_W-1:0] rd_coarse;
    logic [PHASE_W-1:0]  rd_phase;
    logic [SPAD_W-1:0]   rd_spad;
    logic                res_we;
    logic [NUM_W-1:0]    res_idx;
    logic [TOF_W-1:0]    res_tof;
    logic [INT_W-1:0]    res_int;
    logic                conv_done;

    assign num_o = hit_num;

    tdc_hit_capture capture_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .start_i       (start_i),
        .stop_i        (stop_i),
        .phase_i       (phase_i),
        .spad_i        (spad_i),
        .range_i       (range_i),
        .hit_num_i     (hit_num),
        .win_start_o   (win_start),
        .win_done_o    (win_done),
        .hit_we_o      (hit_we),
        .hit_coarse_o  (hit_coarse),
        .hit_phase_o   (hit_phase),
        .hit_spad_o    (hit_spad),
        .start_phase_o (start_phase),
        .range_o       (win_range)
    );

    tdc_hit_store store_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .win_start_i  (win_start),
        .hit_we_i     (hit_we),
        .hit_coarse_i (hit_coarse),
        .hit_phase_i  (hit_phase),
        .hit_spad_i   (hit_spad),
        .rd_idx_i     (rd_idx),
        .hit_num_o    (hit_num),
        .rd_coarse_o  (rd_coarse),
        .rd_phase_o   (rd_phase),
        .rd_spad_o    (rd_spad)
    );

    tdc_result_conv conv_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .win_done_i    (win_done),
        .hit_num_i     (hit_num),
        .start_phase_i (start_phase),
        .range_i       (win_range),
        .rd_coarse_i   (rd_coarse),
        .rd_phase_i    (rd_phase),
        .rd_spad_i     (rd_spad),
        .rd_idx_o      (rd_idx),
        .res_we_o      (res_we),
        .res_idx_o     (res_idx),
        .tof_o         (res_tof),
        .int_o         (res_int),
        .conv_done_o   (conv_done)
    );

    tdc_frame_out frame_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .res_we_i    (res_we),
        .res_idx_i   (res_idx),
        .tof_i       (res_tof),
        .int_i       (res_int),
        .conv_done_i (conv_done),
        .hit_num_i   (hit_num),
        .ready_i     (ready_i),
        .data_o      (data_o),
        .int_o       (int_o),
        .last_o      (last_o),
        .valid_o     (valid_o),
        .irq_o       (irq_o)
    );

endmodule

// File: readout/tdc_frame_out.sv
`timescale 1ns/10ps

module tdc_frame_out (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      res_we_i,
    input  logic [tdc_pkg::NUM_W-1:0] res_idx_i,
    input  logic [tdc_pkg::TOF_W-1:0] tof_i,
    input  logic [tdc_pkg::INT_W-1:0] int_i,
    input  logic                      conv_done_i,
    input  logic [tdc_pkg::NUM_W-1:0] hit_num_i,
    input  logic                      ready_i,
    output logic [tdc_pkg::TOF_W-1:0] data_o,
    output logic [tdc_pkg::INT_W-1:0] int_o,
    output logic                      last_o,
    output logic                      valid_o,
    output logic                      irq_o
);
    import tdc_pkg::*;

    frame_state_e     state;
    frame_state_e     state_nxt;
    logic [TOF_W-1:0] tof_mem [MAX_HITS];
    logic [INT_W-1:0] int_mem [MAX_HITS];
    logic [NUM_W-1:0] frame_num;    // hits in the pending frame
    logic [NUM_W-1:0] beat_idx;
    logic             beat;
    logic             pend;
    logic             irq_q;
    logic             frame_end;

    always_ff @(posedge clk) begin
        if (res_we_i) begin
            tof_mem[res_idx_i] <= tof_i;
            int_mem[res_idx_i] <= int_i;
        end
    end

    // ------------------------------
    // frame FSM
    // ------------------------------
    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (pend && ready_i) begin    // ready only matters here
                    state_nxt = (frame_num == '0) ? EMPTY : BEAT0;
                end
            end
            EMPTY:   state_nxt = IDLE;
            BEAT0:   state_nxt = (frame_num > NUM_W'(1)) ? BEAT1 : IDLE;
            BEAT1:   state_nxt = (frame_num > NUM_W'(2)) ? BEAT2 : IDLE;
            BEAT2:   state_nxt = IDLE;
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= IDLE;
            pend      <= 1'b0;
            frame_num <= '0;
            irq_q     <= 1'b0;
        end else begin
            state <= state_nxt;
            if (conv_done_i) begin
                pend      <= 1'b1;
                frame_num <= hit_num_i;
            end else if (state == IDLE && state_nxt != IDLE) begin
                pend <= 1'b0;
            end
            if (frame_end) begin
                irq_q <= 1'b0;
            end else if (res_we_i || conv_done_i) begin
                irq_q <= 1'b1;
            end
        end
    end

    // ------------------------------
    // beat outputs
    // ------------------------------
    always_comb begin
        beat     = 1'b1;
        beat_idx = '0;
        case (state)
            BEAT0:   beat_idx = '0;
            BEAT1:   beat_idx = NUM_W'(1);
            BEAT2:   beat_idx = NUM_W'(2);
            default: beat     = 1'b0;    // idle or empty frame
        endcase
    end

    assign valid_o   = (state != IDLE);
    assign last_o    = beat & ((beat_idx + 1'b1) == frame_num);
    assign data_o    = beat ? tof_mem[beat_idx] : '0;
    assign int_o     = beat ? int_mem[beat_idx] : '0;
    assign frame_end = (state == EMPTY) | last_o;

    // first conversion output marks the closed window
    assign irq_o = irq_q | res_we_i | conv_done_i;

    // last beat comes with valid under a raised irq, and both drop afterwards
    a_last_ends: assert property (@(posedge clk) disable iff (!rst_n)
        last_o |-> valid_o && irq_o ##1 !valid_o && !irq_o)
        else $error("last_o without a closing valid beat");

endmodule

// File: readout/tdc_result_conv.sv
`timescale 1ns/10ps

module tdc_result_conv (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         win_done_i,
    input  logic [tdc_pkg::NUM_W-1:0]    hit_num_i,
    input  logic [tdc_pkg::PHASE_W-1:0]  start_phase_i,
    input  logic [tdc_pkg::TOF_W-1:0]    range_i,
    input  logic [tdc_pkg::COARSE_W-1:0] rd_coarse_i,
    input  logic [tdc_pkg::PHASE_W-1:0]  rd_phase_i,
    input  logic [tdc_pkg::SPAD_W-1:0]   rd_spad_i,
    output logic [tdc_pkg::NUM_W-1:0]    rd_idx_o,
    output logic                         res_we_o,
    output logic [tdc_pkg::NUM_W-1:0]    res_idx_o,
    output logic [tdc_pkg::TOF_W-1:0]    tof_o,
    output logic [tdc_pkg::INT_W-1:0]    int_o,
    output logic                         conv_done_o
);
    import tdc_pkg::*;

    logic               busy;
    logic               go;
    logic               last_hit;
    logic               last_q;
    logic [NUM_W-1:0]   idx;
    logic [NUM_W-1:0]   num_q;
    logic [NUM_W-1:0]   num_cur;
    logic [FINE_W:0]    stop_ones;
    logic [FINE_W:0]    start_ones;
    logic [FINE_W:0]    spad_ones;
    logic [FINE_W-1:0]  stop_fine;
    logic [FINE_W-1:0]  start_fine;
    logic [TOF_W-1:0]   stop_val;
    logic [TOF_W-1:0]   start_val;
    logic [TOF_W:0]     tof_diff;    // msb is the sign
    logic [TOF_W-1:0]   tof_calc;
    logic [INT_W-1:0]   int_calc;

    function automatic logic [FINE_W:0] count_ones(input logic [PHASE_W-1:0] word);
        logic [FINE_W:0] n;
        n = '0;
        for (int i = 0; i < PHASE_W; i++) begin
            n = n + word[i];
        end
        return n;
    endfunction

    // ------------------------------
    // per hit arithmetic
    // ------------------------------
    assign stop_ones  = count_ones(rd_phase_i);
    assign start_ones = count_ones(start_phase_i);
    assign spad_ones  = count_ones(PHASE_W'(rd_spad_i));

    assign stop_fine  = stop_ones[FINE_W] ? '1 : stop_ones[FINE_W-1:0];    // cap at 31
    assign start_fine = start_ones[FINE_W] ? '1 : start_ones[FINE_W-1:0];
    assign int_calc   = (spad_ones[FINE_W:INT_W] != '0) ? '1 : spad_ones[INT_W-1:0];

    // start sits one coarse step before the first counted edge
    assign stop_val  = {rd_coarse_i, stop_fine};
    assign start_val = {{(COARSE_W-1){1'b0}}, 1'b1, start_fine};
    assign tof_diff  = {1'b0, stop_val} - {1'b0, start_val};
    assign tof_calc  = (tof_diff[TOF_W] || (tof_diff[TOF_W-1:0] > range_i)) ? TOF_OVER
                                                                           : tof_diff[TOF_W-1:0];

    // ------------------------------
    // sequencing, one hit per cycle
    // ------------------------------
    assign rd_idx_o = idx;
    assign num_cur  = busy ? num_q : hit_num_i;
    assign go       = busy | (win_done_i & (hit_num_i != '0));
    assign last_hit = (idx + 1'b1) == num_cur;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy        <= 1'b0;
            idx         <= '0;
            num_q       <= '0;
            last_q      <= 1'b0;
            res_we_o    <= 1'b0;
            conv_done_o <= 1'b0;
        end else begin
            res_we_o    <= go;
            last_q      <= go & last_hit;
            conv_done_o <= last_q | (win_done_i & (hit_num_i == '0));    // done trails last write
            if (go) begin
                busy  <= ~last_hit;
                idx   <= last_hit ? '0 : idx + 1'b1;
                num_q <= num_cur;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (go) begin
            res_idx_o <= idx;
            tof_o     <= tof_calc;
            int_o     <= int_calc;
        end
    end

endmodule

// File: capture/tdc_hit_store.sv
`timescale 1ns/10ps

module tdc_hit_store (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         win_start_i,
    input  logic                         hit_we_i,
    input  logic [tdc_pkg::COARSE_W-1:0] hit_coarse_i,
    input  logic [tdc_pkg::PHASE_W-1:0]  hit_phase_i,
    input  logic [tdc_pkg::SPAD_W-1:0]   hit_spad_i,
    input  logic [tdc_pkg::NUM_W-1:0]    rd_idx_i,
    output logic [tdc_pkg::NUM_W-1:0]    hit_num_o,
    output logic [tdc_pkg::COARSE_W-1:0] rd_coarse_o,
    output logic [tdc_pkg::PHASE_W-1:0]  rd_phase_o,
    output logic [tdc_pkg::SPAD_W-1:0]   rd_spad_o
);
    import tdc_pkg::*;

    logic [NUM_W-1:0]    count_q;
    logic                wr_en;
    logic                fwd;
    logic [COARSE_W-1:0] coarse_mem [MAX_HITS];
    logic [PHASE_W-1:0]  phase_mem  [MAX_HITS];
    logic [SPAD_W-1:0]   spad_mem   [MAX_HITS];

    assign wr_en = hit_we_i & (count_q != NUM_W'(MAX_HITS));    // saturate at three

    // count seen by the rest of the core, write in flight included
    assign hit_num_o = count_q + NUM_W'(wr_en);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count_q <= '0;
        end else if (win_start_i) begin
            count_q <= '0;
        end else if (wr_en) begin
            count_q <= count_q + 1'b1;
        end
    end

    // entries are written in arrival order
    always_ff @(posedge clk) begin
        if (wr_en) begin
            coarse_mem[count_q] <= hit_coarse_i;
            phase_mem[count_q]  <= hit_phase_i;
            spad_mem[count_q]   <= hit_spad_i;
        end
    end

    // ------------------------------
    // read port
    // ------------------------------
    // bypass the entry that lands on this edge
    assign fwd = wr_en & (rd_idx_i == count_q);

    assign rd_coarse_o = fwd ? hit_coarse_i : coarse_mem[rd_idx_i];
    assign rd_phase_o  = fwd ? hit_phase_i  : phase_mem[rd_idx_i];
    assign rd_spad_o   = fwd ? hit_spad_i   : spad_mem[rd_idx_i];

    // capture must stop offering hits once three are held
    a_no_overfill: assert property (@(posedge clk) disable iff (!rst_n)
        hit_we_i |-> count_q != NUM_W'(MAX_HITS))
        else $error("hit write with a full store");

endmodule

// File: capture/tdc_hit_capture.sv
`timescale 1ns/10ps

module tdc_hit_capture (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         start_i,
    input  logic                         stop_i,
    input  logic [tdc_pkg::PHASE_W-1:0]  phase_i,
    input  logic [tdc_pkg::SPAD_W-1:0]   spad_i,
    input  logic [tdc_pkg::TOF_W-1:0]    range_i,
    input  logic [tdc_pkg::NUM_W-1:0]    hit_num_i,
    output logic                         win_start_o,
    output logic                         win_done_o,
    output logic                         hit_we_o,
    output logic [tdc_pkg::COARSE_W-1:0] hit_coarse_o,
    output logic [tdc_pkg::PHASE_W-1:0]  hit_phase_o,
    output logic [tdc_pkg::SPAD_W-1:0]   hit_spad_o,
    output logic [tdc_pkg::PHASE_W-1:0]  start_phase_o,
    output logic [tdc_pkg::TOF_W-1:0]    range_o
);
    import tdc_pkg::*;

    logic                win_open;
    logic [COARSE_W-1:0] coarse_cnt;    // edges since the start edge
    logic                stop_ok;

    // a start inside an open window is dropped
    assign win_start_o = start_i & ~win_open;
    // close when the count reaches the coarse part of the range
    assign win_done_o  = win_open & (coarse_cnt == range_o[TOF_W-1:FINE_W]);

    // the store count already includes a write in flight
    assign stop_ok = win_open & stop_i & ~win_done_o & (hit_num_i != NUM_W'(MAX_HITS));

    // ------------------------------
    // window and coarse counter
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            win_open   <= 1'b0;
            coarse_cnt <= '0;
            range_o    <= RANGE_RST;
        end else if (win_start_o) begin
            win_open   <= 1'b1;
            coarse_cnt <= '0;
            range_o    <= range_i;
        end else if (win_done_o) begin
            win_open   <= 1'b0;
            coarse_cnt <= '0;
        end else if (win_open) begin
            coarse_cnt <= coarse_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (win_start_o) begin
            start_phase_o <= phase_i;    // kept until the next start
        end
    end

    // ------------------------------
    // hit sampling
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hit_we_o <= 1'b0;
        end else begin
            hit_we_o <= stop_ok;
        end
    end

    always_ff @(posedge clk) begin
        if (stop_ok) begin
            hit_coarse_o <= coarse_cnt;
            hit_phase_o  <= phase_i;
            hit_spad_o   <= spad_i;
        end
    end

    // every recorded hit lies before the closing count of its window
    a_hit_in_window: assert property (@(posedge clk) disable iff (!rst_n)
        hit_we_o |-> hit_coarse_o < range_o[TOF_W-1:FINE_W])
        else $error("hit recorded outside the window");

endmodule

// File: common/tdc_pkg.sv
package tdc_pkg;

    // ------------------------------
    // data widths
    // ------------------------------
    localparam int PHASE_W  = 32;    // thermometer phase word from the DLL
    localparam int FINE_W   = 5;     // decoded fine phase
    localparam int COARSE_W = 10;    // coarse count in clk cycles
    localparam int TOF_W    = 15;    // time of flight and range
    localparam int SPAD_W   = 16;    // 4x4 pixel enable mask
    localparam int INT_W    = 4;     // intensity

    // hit bookkeeping
    localparam int MAX_HITS = 3;
    localparam int NUM_W    = 2;

    // ------------------------------
    // fixed values
    // ------------------------------
    // range before the first start, coarse part is 31
    localparam logic [TOF_W-1:0] RANGE_RST = 15'h03FC;
    localparam logic [TOF_W-1:0] TOF_OVER  = 15'h7FFF;    // out of range marker

    // output frame states
    typedef enum logic [2:0] {
        IDLE,     // waiting for a finished conversion and ready
        EMPTY,    // single beat for a window without hits
        BEAT0,
        BEAT1,
        BEAT2
    } frame_state_e;

endpackage
